// ==== rtl/md5crypt_pkt_pkg.sv ====
`default_nettype none

// layout of the comparator configuration packet
// and of the configuration memory the parser fills
package md5crypt_pkt_pkg;

	// first byte of every packet
	localparam logic [7:0] pkt_type_byte = 8'h00;
	// closing byte, anything else here is an error
	localparam logic [7:0] pkt_magic = 8'hCC;

	// salt length byte must be 1..salt_len_max
	localparam int salt_len_max = 16;
	// bytes of iteration count in the packet
	localparam int iter_bytes = 4;

	// configuration memory is 2**cfg_addr_width bytes
	localparam int cfg_addr_width = 5;

	// memory map
	// iteration count, lowest byte first
	localparam int off_iter = 0;
	// salt length, bytes 5..7 read as zero
	localparam int off_salt_len = 4;
	// salt, padded to salt_len_max bytes
	localparam int off_salt = 8;

endpackage

`default_nettype wire

// ==== rtl/md5crypt_cmp_pkg.sv ====
`default_nettype none

// comparator data
// only the low bits of each md5crypt hash are compared here,
// full verification happens elsewhere
package md5crypt_cmp_pkg;

	// compared bits of a hash
	localparam int hash_width = 32;

	// byte lanes per hash word, lowest byte arrives first
	localparam int hash_bytes = hash_width / 8;

	// target slots unless the top level says otherwise
	// any power of two from 4 upward works
	localparam int num_hashes_default = 16;

endpackage

`default_nettype wire

// ==== rtl/md5crypt_cmp_config.sv ====
`timescale 1ns/100ps
`default_nettype none

module md5crypt_cmp_config #(
	parameter int num_hashes = md5crypt_cmp_pkg::num_hashes_default
) (
	input  wire CLK,
	input  wire rst_n,
	// low: only packets without target hashes are legal
	input  wire mode_cmp,

	input  wire [7:0] din,
	input  wire wr_en,
	output logic full,
	output logic err,

	// handshake with the comparator
	output logic new_cmp_config,
	input  wire cmp_config_applied,

	// target byte stream into the comparator
	output logic [$clog2(num_hashes):0] hash_count,
	output logic [$clog2(num_hashes)+$clog2(md5crypt_cmp_pkg::hash_bytes)-1:0] cmp_wr_addr,
	output logic cmp_wr_en,
	output logic [7:0] cmp_din,

	// asynchronous read port for other subsystems
	input  wire [md5crypt_pkt_pkg::cfg_addr_width-1:0] cfg_addr,
	output logic [7:0] cfg_dout
);

	localparam int idx_w = $clog2(num_hashes);
	localparam int cnt_w = idx_w + 1;
	localparam int lane_w = $clog2(md5crypt_cmp_pkg::hash_bytes);
	localparam int addr_w = idx_w + lane_w;
	localparam int cfg_aw = md5crypt_pkt_pkg::cfg_addr_width;

	// last salt byte in memory
	localparam logic [cfg_aw-1:0] salt_last =
		cfg_aw'(md5crypt_pkt_pkg::off_salt + md5crypt_pkt_pkg::salt_len_max - 1);
	localparam logic [1:0] iter_last = 2'(md5crypt_pkt_pkg::iter_bytes - 1);

	// one-hot packet walk
	localparam logic [9:0] s_idle     = 10'b00_0000_0001;
	localparam logic [9:0] s_wait     = 10'b00_0000_0010;
	localparam logic [9:0] s_salt_len = 10'b00_0000_0100;
	localparam logic [9:0] s_salt     = 10'b00_0000_1000;
	localparam logic [9:0] s_iter     = 10'b00_0001_0000;
	localparam logic [9:0] s_cnt0     = 10'b00_0010_0000;
	localparam logic [9:0] s_cnt1     = 10'b00_0100_0000;
	localparam logic [9:0] s_data     = 10'b00_1000_0000;
	localparam logic [9:0] s_magic    = 10'b01_0000_0000;
	localparam logic [9:0] s_error    = 10'b10_0000_0000;

	logic [9:0] state;

	logic accept;
	logic [cfg_aw-1:0] salt_addr;
	logic [1:0] iter_cnt;
	// low hash count byte, waits for the high one
	logic [7:0] cnt_lo;
	logic [15:0] count_in;
	logic count_ok;
	logic [addr_w-1:0] byte_cnt;
	logic [addr_w-1:0] wr_last;

	// configuration memory
	logic [7:0] cfg_mem [2**cfg_aw];
	logic mem_wr_en;
	logic [cfg_aw-1:0] mem_wr_addr;
	logic cfg_unused;

	assign accept = wr_en & ~full;

	// stalled while the comparator applies the packet, forever after an error
	assign full = (state == s_wait) | (state == s_error);
	assign err = state == s_error;
	assign new_cmp_config = state == s_wait;

	// full 16-bit count as seen on the second count byte
	assign count_in = {din, cnt_lo};
	assign count_ok = (count_in <= 16'(num_hashes)) && (mode_cmp || count_in == 16'd0);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			hash_count <= '0;
			cnt_lo <= '0;
			salt_addr <= '0;
			iter_cnt <= '0;
			byte_cnt <= '0;
			wr_last <= '0;
			cmp_wr_en <= 1'b0;
		end else begin
			// target bytes go out one cycle after they are taken
			cmp_wr_en <= accept & (state == s_data);

			if (state == s_wait) begin
				if (cmp_config_applied)
					state <= s_salt_len;
			end else if (accept) begin
				case (state)
				s_idle:
					state <= (din == md5crypt_pkt_pkg::pkt_type_byte) ? s_wait : s_error;
				s_salt_len: begin
					salt_addr <= cfg_aw'(md5crypt_pkt_pkg::off_salt);
					iter_cnt <= '0;
					if (din == 8'd0 || din > 8'(md5crypt_pkt_pkg::salt_len_max))
						state <= s_error;
					else
						state <= s_salt;
				end
				s_salt: begin
					salt_addr <= salt_addr + 1'b1;
					if (salt_addr == salt_last)
						state <= s_iter;
				end
				s_iter: begin
					iter_cnt <= iter_cnt + 1'b1;
					if (iter_cnt == iter_last)
						state <= s_cnt0;
				end
				s_cnt0: begin
					cnt_lo <= din;
					if (!mode_cmp && din != 8'd0)
						state <= s_error;
					else
						state <= s_cnt1;
				end
				s_cnt1: begin
					hash_count <= cnt_w'(count_in);
					byte_cnt <= '0;
					// address of the last target byte
					wr_last <= addr_w'({count_in, {lane_w{1'b0}}} - 1'b1);
					if (!count_ok)
						state <= s_error;
					else if (count_in == 16'd0)
						state <= s_magic;
					else
						state <= s_data;
				end
				s_data: begin
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == wr_last)
						state <= s_magic;
				end
				s_magic:
					state <= (din == md5crypt_pkt_pkg::pkt_magic) ? s_idle : s_error;
				s_error:
					state <= s_error;
				default:
					state <= s_error;
				endcase
			end
		end
	end

	// target byte and its address, registered with cmp_wr_en
	always_ff @(posedge CLK) begin
		if (accept && state == s_data) begin
			cmp_din <= din;
			cmp_wr_addr <= byte_cnt;
		end
	end

	// salt length, salt and iteration count land in memory
	assign mem_wr_en = accept & ((state == s_salt_len) | (state == s_salt) | (state == s_iter));

	always_comb begin
		if (state == s_salt_len)
			mem_wr_addr = cfg_aw'(md5crypt_pkt_pkg::off_salt_len);
		else if (state == s_salt)
			mem_wr_addr = salt_addr;
		else
			mem_wr_addr = cfg_aw'(md5crypt_pkt_pkg::off_iter) + cfg_aw'(iter_cnt);
	end

	always_ff @(posedge CLK) begin
		if (mem_wr_en)
			cfg_mem[mem_wr_addr] <= din;
	end

	// bytes never written read as zero
	// the upper salt length bytes and the space past the salt
	assign cfg_unused = (cfg_addr > cfg_aw'(md5crypt_pkt_pkg::off_salt_len)
		&& cfg_addr < cfg_aw'(md5crypt_pkt_pkg::off_salt)) || cfg_addr > salt_last;

	assign cfg_dout = cfg_unused ? 8'd0 : cfg_mem[cfg_addr];

endmodule

`default_nettype wire

// ==== rtl/md5crypt_hash_collect.sv ====
`timescale 1ns/100ps
`default_nettype none

module md5crypt_hash_collect (
	input  wire CLK,
	input  wire rst_n,

	// computed hash bytes, lowest byte first
	input  wire [7:0] hash_din,
	input  wire hash_wr_en,
	output logic hash_full,

	// to the comparator
	output logic word_valid,
	output logic [md5crypt_cmp_pkg::hash_width-1:0] hash_word,
	input  wire word_taken
);

	localparam int lane_w = $clog2(md5crypt_cmp_pkg::hash_bytes);
	localparam logic [lane_w-1:0] lane_last = lane_w'(md5crypt_cmp_pkg::hash_bytes - 1);

	logic [lane_w-1:0] lane;
	logic accept;

	// back-pressure while a finished word waits
	assign hash_full = word_valid;
	assign accept = hash_wr_en & ~hash_full;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			lane <= '0;
			word_valid <= 1'b0;
		end else if (accept) begin
			// lane wraps to 0 after the last byte
			lane <= lane + 1'b1;
			if (lane == lane_last)
				word_valid <= 1'b1;
		end else if (word_taken) begin
			word_valid <= 1'b0;
		end
	end

	// each byte into its own lane
	always_ff @(posedge CLK) begin
		if (accept)
			hash_word[8*lane +: 8] <= hash_din;
	end

endmodule

`default_nettype wire

// ==== rtl/md5crypt_comparator.sv ====
`timescale 1ns/100ps
`default_nettype none

module md5crypt_comparator #(
	parameter int num_hashes = md5crypt_cmp_pkg::num_hashes_default
) (
	input  wire CLK,
	input  wire rst_n,

	// configuration handshake with the parser
	input  wire new_cmp_config,
	output logic cmp_config_applied,

	// target byte stream
	input  wire [$clog2(num_hashes):0] hash_count,
	input  wire [$clog2(num_hashes)+$clog2(md5crypt_cmp_pkg::hash_bytes)-1:0] cmp_wr_addr,
	input  wire cmp_wr_en,
	input  wire [7:0] cmp_din,

	// computed words from the collector
	input  wire word_valid,
	input  wire [md5crypt_cmp_pkg::hash_width-1:0] hash_word,
	output logic word_taken,

	// search result
	output logic cmp_result,
	output logic cmp_equal,
	output logic [$clog2(num_hashes)-1:0] cmp_index
);

	localparam int idx_w = $clog2(num_hashes);
	localparam int cnt_w = idx_w + 1;
	localparam int lane_w = $clog2(md5crypt_cmp_pkg::hash_bytes);
	localparam int addr_w = idx_w + lane_w;

	typedef enum logic [1:0] {st_idle, st_apply, st_search} ctl_t;

	ctl_t state;

	// target words, one byte lane per write
	logic [md5crypt_cmp_pkg::hash_bytes-1:0][7:0] targets [num_hashes];

	logic [md5crypt_cmp_pkg::hash_width-1:0] word;
	// slots valid for new searches, zero until the target set is complete
	logic [cnt_w-1:0] active_cnt;
	// slots for the search in progress
	logic [cnt_w-1:0] srch_cnt;
	logic [idx_w-1:0] idx;
	logic [addr_w-1:0] last_addr;
	logic set_done;
	logic hit;
	logic scan_end;
	logic take;

	always_ff @(posedge CLK) begin
		if (cmp_wr_en)
			targets[cmp_wr_addr[addr_w-1:lane_w]][cmp_wr_addr[lane_w-1:0]] <= cmp_din;
	end

	// last target byte written, the new set is whole
	assign last_addr = addr_w'({hash_count, {lane_w{1'b0}}} - 1'b1);
	assign set_done = cmp_wr_en && cmp_wr_addr == last_addr;

	// a pending configuration has priority over waiting words
	assign take = state == st_idle && !new_cmp_config && word_valid;

	// an empty set never matches whatever the memory holds
	assign hit = srch_cnt != '0 && targets[idx] == word;
	assign scan_end = srch_cnt == '0 || {1'b0, idx} == srch_cnt - 1'b1;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			active_cnt <= '0;
			srch_cnt <= '0;
			idx <= '0;
			cmp_config_applied <= 1'b0;
			word_taken <= 1'b0;
			cmp_result <= 1'b0;
		end else begin
			cmp_config_applied <= 1'b0;
			word_taken <= 1'b0;
			cmp_result <= 1'b0;

			if (set_done)
				active_cnt <= hash_count;

			case (state)
			st_idle:
				if (new_cmp_config) begin
					// old targets are about to be overwritten
					cmp_config_applied <= 1'b1;
					active_cnt <= '0;
					state <= st_apply;
				end else if (take) begin
					word_taken <= 1'b1;
					srch_cnt <= active_cnt;
					idx <= '0;
					state <= st_search;
				end
			// parser drops new_cmp_config on this edge
			st_apply:
				state <= st_idle;
			st_search:
				if (hit || scan_end)
					state <= st_idle;
				else
					idx <= idx + 1'b1;
			default:
				state <= st_idle;
			endcase

			if (state == st_search && (hit || scan_end))
				cmp_result <= 1'b1;
		end
	end

	// searched word and result payload
	always_ff @(posedge CLK) begin
		if (take)
			word <= hash_word;
		if (state == st_search && (hit || scan_end)) begin
			cmp_equal <= hit;
			cmp_index <= idx;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/md5crypt_cmp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module md5crypt_cmp_top #(
	parameter int num_hashes = md5crypt_cmp_pkg::num_hashes_default
) (
	input  wire CLK,
	input  wire rst_n,

	// configuration packet stream
	input  wire mode_cmp,
	input  wire [7:0] din,
	input  wire wr_en,
	output logic full,
	output logic err,

	// configuration readback
	input  wire [md5crypt_pkt_pkg::cfg_addr_width-1:0] cfg_addr,
	output logic [7:0] cfg_dout,

	// computed hash bytes
	input  wire [7:0] hash_din,
	input  wire hash_wr_en,
	output logic hash_full,

	// match results
	output logic cmp_result,
	output logic cmp_equal,
	output logic [$clog2(num_hashes)-1:0] cmp_index
);

	localparam int idx_w = $clog2(num_hashes);
	localparam int lane_w = $clog2(md5crypt_cmp_pkg::hash_bytes);

	// parser to comparator
	logic new_cmp_config;
	logic cmp_config_applied;
	logic [idx_w:0] hash_count;
	logic [idx_w+lane_w-1:0] cmp_wr_addr;
	logic cmp_wr_en;
	logic [7:0] cmp_din;

	// collector to comparator
	logic word_valid;
	logic word_taken;
	logic [md5crypt_cmp_pkg::hash_width-1:0] hash_word;

	md5crypt_cmp_config #(
		.num_hashes(num_hashes)
	) config0 (
		.CLK(CLK),
		.rst_n(rst_n),
		.mode_cmp(mode_cmp),
		.din(din),
		.wr_en(wr_en),
		.full(full),
		.err(err),
		.new_cmp_config(new_cmp_config),
		.cmp_config_applied(cmp_config_applied),
		.hash_count(hash_count),
		.cmp_wr_addr(cmp_wr_addr),
		.cmp_wr_en(cmp_wr_en),
		.cmp_din(cmp_din),
		.cfg_addr(cfg_addr),
		.cfg_dout(cfg_dout)
	);

	md5crypt_hash_collect collect0 (
		.CLK(CLK),
		.rst_n(rst_n),
		.hash_din(hash_din),
		.hash_wr_en(hash_wr_en),
		.hash_full(hash_full),
		.word_valid(word_valid),
		.hash_word(hash_word),
		.word_taken(word_taken)
	);

	md5crypt_comparator #(
		.num_hashes(num_hashes)
	) cmp0 (
		.CLK(CLK),
		.rst_n(rst_n),
		.new_cmp_config(new_cmp_config),
		.cmp_config_applied(cmp_config_applied),
		.hash_count(hash_count),
		.cmp_wr_addr(cmp_wr_addr),
		.cmp_wr_en(cmp_wr_en),
		.cmp_din(cmp_din),
		.word_valid(word_valid),
		.hash_word(hash_word),
		.word_taken(word_taken),
		.cmp_result(cmp_result),
		.cmp_equal(cmp_equal),
		.cmp_index(cmp_index)
	);

endmodule

`default_nettype wire

// ==== tb/md5crypt_cmp_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module md5crypt_cmp_tb;

	localparam int num_hashes = md5crypt_cmp_pkg::num_hashes_default;
	localparam int salt_max = md5crypt_pkt_pkg::salt_len_max;
	// words per phase
	localparam int words1 = 24;
	localparam int words2 = 16;
	localparam int words3 = 8;
	localparam int hold_cycles = 8;
	// packet with every slot used plus handshake and settle cycles
	localparam int pkt_full = 25 + 4 * num_hashes + 8;
	// each error case costs a reset, at most one short packet and the hold check
	localparam int err_cycles = 4 * (33 + 4 + hold_cycles);
	localparam int limit = 2 * pkt_full + 33 + err_cycles
		+ (words1 + words2 + words3) * (num_hashes + 8)
		+ 3 * (num_hashes + 8) + 3 * 24 + 4 + 100;

	logic CLK;
	logic rst_n;
	logic mode_cmp;
	logic [7:0] din;
	logic wr_en;
	logic full;
	logic err;
	logic [md5crypt_pkt_pkg::cfg_addr_width-1:0] cfg_addr;
	logic [7:0] cfg_dout;
	logic [7:0] hash_din;
	logic hash_wr_en;
	logic hash_full;
	logic cmp_result;
	logic cmp_equal;
	logic [$clog2(num_hashes)-1:0] cmp_index;

	// current configuration as the testbench sees it
	logic [7:0] salt [salt_max];
	logic [7:0] iter [4];
	int salt_len;
	logic [31:0] tgt [num_hashes];
	// previous target set reused to provoke stale matches
	logic [31:0] old_tgt [num_hashes];
	int cur_count;
	logic [7:0] pkt_q [$];

	// expected slot per word or -1 for a miss
	int exp_q [$];
	int n_sent;
	int n_results;
	int cycles;

	md5crypt_cmp_top #(
		.num_hashes(num_hashes)
	) dut0 (
		.CLK(CLK),
		.rst_n(rst_n),
		.mode_cmp(mode_cmp),
		.din(din),
		.wr_en(wr_en),
		.full(full),
		.err(err),
		.cfg_addr(cfg_addr),
		.cfg_dout(cfg_dout),
		.hash_din(hash_din),
		.hash_wr_en(hash_wr_en),
		.hash_full(hash_full),
		.cmp_result(cmp_result),
		.cmp_equal(cmp_equal),
		.cmp_index(cmp_index)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// run limit
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("SOME TESTS FAILED");
			$fatal(1, "run stopped on timeout");
		end
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// lowest slot below count that holds w or -1
	function automatic int find_lowest_slot(input logic [31:0] slots [num_hashes],
		input int count, input logic [31:0] w);
		int i;
		for (i = 0; i < count; i++) begin
			if (slots[i] == w)
				return i;
		end
		return -1;
	endfunction

	// pairs every result pulse with the oldest word in flight
	always @(negedge CLK) begin
		int e;
		if (cmp_result) begin
			if (exp_q.size() == 0) begin
				$display("cmp_result pulsed at %0t with no word outstanding", $time);
				$display("SOME TESTS FAILED");
				$fatal(1, "unexpected result");
			end else begin
				e = exp_q.pop_front();
				compare_value("cmp_equal", (e >= 0) ? 32'd1 : 32'd0, 32'(cmp_equal));
				if (e >= 0)
					compare_value("cmp_index", 32'(e), 32'(cmp_index));
				n_results++;
			end
		end
	end

	task automatic apply_reset();
		@(negedge CLK);
		rst_n = 1'b0;
		repeat (4) @(negedge CLK);
		rst_n = 1'b1;
	endtask

	task automatic randomize_config();
		int i;
		salt_len = 1 + int'($urandom % 32'(salt_max));
		for (i = 0; i < salt_max; i++)
			salt[i] = 8'($urandom);
		for (i = 0; i < 4; i++)
			iter[i] = 8'($urandom);
	endtask

	// type, salt length, salt, iteration, count, targets, magic
	task automatic build_packet(input int slen, input int count, input logic [7:0] magic);
		int i;
		int j;
		pkt_q.delete();
		pkt_q.push_back(md5crypt_pkt_pkg::pkt_type_byte);
		pkt_q.push_back(8'(slen));
		for (i = 0; i < salt_max; i++)
			pkt_q.push_back(salt[i]);
		for (i = 0; i < 4; i++)
			pkt_q.push_back(iter[i]);
		pkt_q.push_back(8'(count % 256));
		pkt_q.push_back(8'(count / 256));
		for (i = 0; i < count; i++) begin
			for (j = 0; j < 4; j++)
				pkt_q.push_back(tgt[i][8*j +: 8]);
		end
		pkt_q.push_back(magic);
	endtask

	// wr_en only while full is low
	task automatic send_cfg_byte(input logic [7:0] b);
		logic sent;
		sent = 1'b0;
		while (!sent) begin
			@(negedge CLK);
			din = b;
			wr_en = ~full;
			sent = ~full;
		end
	endtask

	task automatic send_cfg_bytes(input int n);
		int i;
		for (i = 0; i < n; i++)
			send_cfg_byte(pkt_q[i]);
		@(negedge CLK);
		wr_en = 1'b0;
	endtask

	task automatic check_cfg_mem();
		int a;
		logic [7:0] e;
		for (a = 0; a < md5crypt_pkt_pkg::off_salt + salt_max; a++) begin
			if (a < md5crypt_pkt_pkg::off_salt_len)
				e = iter[a - md5crypt_pkt_pkg::off_iter];
			else if (a == md5crypt_pkt_pkg::off_salt_len)
				e = 8'(salt_len);
			else if (a < md5crypt_pkt_pkg::off_salt)
				e = 8'd0;
			else
				e = salt[a - md5crypt_pkt_pkg::off_salt];
			@(negedge CLK);
			cfg_addr = 5'(a);
			@(posedge CLK);
			compare_value("cfg_dout", 32'(e), 32'(cfg_dout));
		end
	endtask

	// bytes stay offered while hash_full holds them back
	task automatic send_hash_word(input logic [31:0] w);
		int i;
		i = 0;
		while (i < 4) begin
			@(negedge CLK);
			hash_wr_en = 1'b1;
			hash_din = w[8*i +: 8];
			if (!hash_full)
				i++;
		end
		// the fourth byte completes the word and closes the input
		@(negedge CLK);
		compare_value("hash_full", 32'd1, 32'(hash_full));
	endtask

	// mix of current targets, old targets and random words
	task automatic run_words(input int n);
		int k;
		int pick;
		int slot;
		logic [31:0] w;
		for (k = 0; k < n; k++) begin
			pick = int'($urandom % 3);
			if (pick == 0) begin
				slot = int'($urandom % 32'((cur_count > 0) ? cur_count : num_hashes));
				w = tgt[slot];
			end else if (pick == 1) begin
				slot = int'($urandom % 32'(num_hashes));
				w = old_tgt[slot];
			end else begin
				w = $urandom;
			end
			exp_q.push_back(find_lowest_slot(tgt, cur_count, w));
			n_sent++;
			send_hash_word(w);
		end
		@(negedge CLK);
		hash_wr_en = 1'b0;
		while (n_results < n_sent)
			@(negedge CLK);
		// no late or doubled result
		repeat (num_hashes + 8) @(negedge CLK);
	endtask

	// the bad byte is the last one sent
	task automatic expect_error(input string what, input int n_bytes);
		send_cfg_bytes(n_bytes);
		repeat (hold_cycles) begin
			@(negedge CLK);
			if (!err) begin
				$display("err stayed low after %s at %0t", what, $time);
				$display("SOME TESTS FAILED");
				$fatal(1, "missing error");
			end
			if (!full) begin
				$display("full dropped in the error state after %s at %0t", what, $time);
				$display("SOME TESTS FAILED");
				$fatal(1, "full not held");
			end
		end
	endtask

	task automatic new_targets(input int count);
		int i;
		for (i = 0; i < num_hashes; i++) begin
			old_tgt[i] = tgt[i];
			tgt[i] = $urandom;
		end
		// duplicate so the lowest slot must win
		if (count > 2)
			tgt[count - 1] = tgt[0];
		if (count > 4)
			tgt[count / 2] = tgt[1];
	endtask

	initial begin
		rst_n = 1'b0;
		mode_cmp = 1'b1;
		din = 8'd0;
		wr_en = 1'b0;
		cfg_addr = '0;
		hash_din = 8'd0;
		hash_wr_en = 1'b0;
		n_sent = 0;
		n_results = 0;
		cycles = 0;
		void'($urandom(32'hf71ae5f1));
		repeat (4) @(negedge CLK);
		rst_n = 1'b1;

		// full target set with duplicates
		new_targets(num_hashes);
		new_targets(num_hashes);
		randomize_config();
		build_packet(salt_len, num_hashes, md5crypt_pkt_pkg::pkt_magic);
		send_cfg_bytes(pkt_q.size());
		cur_count = num_hashes;
		repeat (3) @(negedge CLK);
		compare_value("err", 32'd0, 32'(err));
		check_cfg_mem();
		run_words(words1);

		// second packet replaces the targets with a shorter set
		new_targets(num_hashes / 2 + 2);
		randomize_config();
		build_packet(salt_len, num_hashes / 2 + 2, md5crypt_pkt_pkg::pkt_magic);
		send_cfg_bytes(pkt_q.size());
		cur_count = num_hashes / 2 + 2;
		repeat (3) @(negedge CLK);
		compare_value("err", 32'd0, 32'(err));
		check_cfg_mem();
		run_words(words2);

		// empty set is legal with mode_cmp low and matches nothing
		mode_cmp = 1'b0;
		randomize_config();
		build_packet(salt_len, 0, md5crypt_pkt_pkg::pkt_magic);
		send_cfg_bytes(pkt_q.size());
		cur_count = 0;
		repeat (3) @(negedge CLK);
		compare_value("err", 32'd0, 32'(err));
		check_cfg_mem();
		run_words(words3);

		// each error case starts from reset
		apply_reset();
		mode_cmp = 1'b1;
		build_packet(0, 0, md5crypt_pkt_pkg::pkt_magic);
		expect_error("salt length 0", 2);

		apply_reset();
		build_packet(salt_max + 1, 0, md5crypt_pkt_pkg::pkt_magic);
		expect_error("salt length 17", 2);

		apply_reset();
		build_packet(salt_len, 0, ~md5crypt_pkt_pkg::pkt_magic);
		expect_error("wrong magic byte", pkt_q.size());

		// stops at the low count byte
		apply_reset();
		mode_cmp = 1'b0;
		build_packet(salt_len, 1, md5crypt_pkt_pkg::pkt_magic);
		expect_error("hash count with mode_cmp low", 23);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== md5crypt_cmp_top.f ====
rtl/md5crypt_pkt_pkg.sv
rtl/md5crypt_cmp_pkg.sv
rtl/md5crypt_cmp_config.sv
rtl/md5crypt_hash_collect.sv
rtl/md5crypt_comparator.sv
rtl/md5crypt_cmp_top.sv
tb/md5crypt_cmp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
# exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/100ps --top-module md5crypt_cmp_tb \
	-f md5crypt_cmp_top.f -o md5crypt_cmp_sim \
	&& ./obj_dir/md5crypt_cmp_sim \
	|| exit 1
